// File: design/alu.sv
////////////////////
// Integer ALU. zero and signBit always describe a - b,
// whatever op is selected, for the branch test.
////////////////////
`default_nettype none

module alu (
    input  wire ctrlPkg::aluOpT op,
    input  wire isaPkg::wordT   a,
    input  wire isaPkg::wordT   b,
    input  wire logic [4:0]     shamt,
    output isaPkg::wordT        result,
    output logic                zero,
    output logic                signBit
);

    isaPkg::wordT diff;

    assign diff    = a - b;
    assign zero    = (diff == '0);
    assign signBit = diff[31];

    always_comb
    begin
        case (op)
            ctrlPkg::ALU_ADD:
                result = a + b;
            ctrlPkg::ALU_SUB:
                result = diff;
            ctrlPkg::ALU_AND:
                result = a & b;
            ctrlPkg::ALU_OR:
                result = a | b;
            ctrlPkg::ALU_XOR:
                result = a ^ b;
            ctrlPkg::ALU_NOR:
                result = ~(a | b);
            ctrlPkg::ALU_SLT:
                result = {31'b0, $signed(a) < $signed(b)};
            ctrlPkg::ALU_SLTU:
                result = {31'b0, a < b};
            ctrlPkg::ALU_SLL:
                result = b << shamt; // Shifts act on rt
            ctrlPkg::ALU_SRL:
                result = b >> shamt;
            ctrlPkg::ALU_SRA:
                result = $signed(b) >>> shamt;
            ctrlPkg::ALU_LUI:
                result = {b[15:0], 16'h0000};
            default:
                result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/cpuCore.sv
////////////////////
// Single-cycle MIPS32 subset core, one instruction per clock.
// Program is loaded while rstN is low; commit port shows each write-back.
////////////////////
`default_nettype none

module cpuCore #(
    parameter int imemWords = 256,
    parameter int dmemWords = 256
) (
    input  wire logic                         clk,
    input  wire logic                         rstN,
    input  wire logic                         loadEn,
    input  wire logic [$clog2(imemWords)-1:0] loadAddr,
    input  wire isaPkg::wordT                 loadData,
    output logic                              commitEn,
    output isaPkg::regAddrT                   commitReg,
    output isaPkg::wordT                      commitData,
    output isaPkg::wordT                      commitPc,
    output logic                              halted
);

    isaPkg::wordT     instr, pc, pcPlus4, rsData, rtData, immExt, aluB, aluResult;
    isaPkg::wordT     memData, wbData;
    isaPkg::regAddrT  wbReg;
    isaPkg::opcodeT   opcode;
    isaPkg::functT    funct;
    ctrlPkg::aluOpT   aluOp;
    ctrlPkg::regDstT  regDst;
    ctrlPkg::memSizeT memSize;
    ctrlPkg::pcSrcT   pcSrc;
    logic [1:0]       branchCond;
    logic             aluSrcImm, immZeroExt, regWrite, memRead, memWrite, halt;
    logic             zero, signBit;

    assign opcode = isaPkg::opcodeT'(instr[isaPkg::opLsb +: 6]);
    assign funct  = isaPkg::functT'(instr[isaPkg::functLsb +: 6]);
    assign immExt = immZeroExt ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    assign aluB   = aluSrcImm ? immExt : rtData;

    always_comb
    begin
        case (regDst)
            ctrlPkg::DST_RD:   wbReg = instr[isaPkg::rdLsb +: 5];
            ctrlPkg::DST_LINK: wbReg = 5'd31;
            default:           wbReg = instr[isaPkg::rtLsb +: 5];
        endcase
    end

    assign wbData = (regDst == ctrlPkg::DST_LINK) ? pcPlus4 : (memRead ? memData : aluResult);

    // Quiet during reset and after SYSCALL
    assign commitEn   = rstN && !halted && regWrite && (wbReg != 5'd0);
    assign commitReg  = wbReg;
    assign commitData = wbData;
    assign commitPc   = pc;

    fetchUnit #(.imemWords(imemWords)) fetchInst (
        .clk(clk), .rstN(rstN), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .pcSrc(pcSrc), .branchCond(branchCond), .zero(zero), .signBit(signBit),
        .halt(halt), .immOffset(immExt), .jumpTarget(instr[25:0]), .regTarget(rsData),
        .instr(instr), .pc(pc), .pcPlus4(pcPlus4), .halted(halted)
    );

    decoder decoderInst (
        .opcode(opcode), .funct(funct), .aluOp(aluOp), .aluSrcImm(aluSrcImm),
        .immZeroExt(immZeroExt), .regDst(regDst), .regWrite(regWrite),
        .memRead(memRead), .memWrite(memWrite), .memSize(memSize), .pcSrc(pcSrc),
        .branchCond(branchCond), .halt(halt)
    );

    regFile regFileInst (
        .clk(clk), .rstN(rstN),
        .readAddrA(instr[isaPkg::rsLsb +: 5]), .readAddrB(instr[isaPkg::rtLsb +: 5]),
        .readDataA(rsData), .readDataB(rtData),
        .writeEn(regWrite && !halted), .writeAddr(wbReg), .writeData(wbData)
    );

    alu aluInst (
        .op(aluOp), .a(rsData), .b(aluB), .shamt(instr[isaPkg::shamtLsb +: 5]),
        .result(aluResult), .zero(zero), .signBit(signBit)
    );

    dataMem #(.dmemWords(dmemWords)) dataMemInst (
        .clk(clk), .rstN(rstN), .addr(aluResult), .writeData(rtData),
        .memRead(memRead), .memWrite(memWrite), .memSize(memSize), .readData(memData)
    );

endmodule

`default_nettype wire

// File: design/ctrlPkg.sv
////////////////////
// Datapath control encodings driven by the decoder.
////////////////////
`default_nettype none

package ctrlPkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } aluOpT;

    typedef enum logic [1:0] {
        DST_RT,
        DST_RD,
        DST_LINK // Register 31
    } regDstT;

    typedef enum logic [1:0] {
        BYTE_S,
        BYTE_U,
        WORD
    } memSizeT;

    typedef enum logic [1:0] {
        SEQ,
        BRANCH,
        JUMP,
        JREG
    } pcSrcT;

endpackage

`default_nettype wire

// File: design/dataMem.sv
////////////////////
// Word-addressed data memory, byte or word access.
// Address bits above the depth are ignored; word accesses must be aligned.
////////////////////
`default_nettype none

module dataMem #(
    parameter int dmemWords = 256
) (
    input  wire logic             clk,
    input  wire logic             rstN,
    input  wire isaPkg::wordT     addr,
    input  wire isaPkg::wordT     writeData,
    input  wire logic             memRead,
    input  wire logic             memWrite,
    input  wire ctrlPkg::memSizeT memSize,
    output isaPkg::wordT          readData
);

    localparam int dmemAddrBits = $clog2(dmemWords);

    isaPkg::wordT                mem [dmemWords];
    logic [dmemAddrBits-1:0]     index;
    logic [1:0]                  lane;
    isaPkg::wordT                word;
    logic [7:0]                  byteVal;

    assign index   = addr[dmemAddrBits+1:2];
    assign lane    = addr[1:0];
    assign word    = mem[index];
    assign byteVal = word[8*lane +: 8]; // Little-endian lanes

    always_ff @(posedge clk)
    begin
        if (rstN && memWrite)
        begin
            if (memSize == ctrlPkg::WORD)
                mem[index] <= writeData;
            else
                mem[index][8*lane +: 8] <= writeData[7:0];
        end
    end

    always_comb
    begin
        if (!memRead)
            readData = '0;
        else if (memSize == ctrlPkg::BYTE_S)
            readData = {{24{byteVal[7]}}, byteVal};
        else if (memSize == ctrlPkg::BYTE_U)
            readData = {24'h000000, byteVal};
        else
            readData = word;
    end

    wordAligned: assert property (@(posedge clk) disable iff (!rstN)
        ((memRead || memWrite) && memSize == ctrlPkg::WORD) |-> addr[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: design/decoder.sv
////////////////////
// Control decoder, purely combinational.
// Unsupported opcodes and function codes leave every output inactive.
////////////////////
`default_nettype none

module decoder (
    input  wire isaPkg::opcodeT  opcode,
    input  wire isaPkg::functT   funct,
    output ctrlPkg::aluOpT       aluOp,
    output logic                 aluSrcImm,
    output logic                 immZeroExt,
    output ctrlPkg::regDstT      regDst,
    output logic                 regWrite,
    output logic                 memRead,
    output logic                 memWrite,
    output ctrlPkg::memSizeT     memSize,
    output ctrlPkg::pcSrcT       pcSrc,
    output logic [1:0]           branchCond,
    output logic                 halt
);

    always_comb
    begin
        aluOp      = ctrlPkg::ALU_ADD;
        aluSrcImm  = 1'b0;
        immZeroExt = 1'b0;
        regDst     = ctrlPkg::DST_RT;
        regWrite   = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        memSize    = ctrlPkg::WORD;
        pcSrc      = ctrlPkg::SEQ;
        branchCond = 2'b00;
        halt       = 1'b0;

        case (opcode)
            isaPkg::OP_SPECIAL:
            begin
                regDst   = ctrlPkg::DST_RD;
                regWrite = 1'b1;
                case (funct)
                    isaPkg::FN_ADD, isaPkg::FN_ADDU: aluOp = ctrlPkg::ALU_ADD;
                    isaPkg::FN_SUB, isaPkg::FN_SUBU: aluOp = ctrlPkg::ALU_SUB;
                    isaPkg::FN_AND:  aluOp = ctrlPkg::ALU_AND;
                    isaPkg::FN_OR:   aluOp = ctrlPkg::ALU_OR;
                    isaPkg::FN_XOR:  aluOp = ctrlPkg::ALU_XOR;
                    isaPkg::FN_NOR:  aluOp = ctrlPkg::ALU_NOR;
                    isaPkg::FN_SLT:  aluOp = ctrlPkg::ALU_SLT;
                    isaPkg::FN_SLTU: aluOp = ctrlPkg::ALU_SLTU;
                    isaPkg::FN_SLL:  aluOp = ctrlPkg::ALU_SLL;
                    isaPkg::FN_SRL:  aluOp = ctrlPkg::ALU_SRL;
                    isaPkg::FN_SRA:  aluOp = ctrlPkg::ALU_SRA;
                    isaPkg::FN_JR:
                    begin
                        regWrite = 1'b0;
                        pcSrc    = ctrlPkg::JREG;
                    end
                    isaPkg::FN_SYSCALL:
                    begin
                        regWrite = 1'b0;
                        halt     = 1'b1;
                    end
                    default: regWrite = 1'b0;
                endcase
            end

            isaPkg::OP_J:
                pcSrc = ctrlPkg::JUMP;

            isaPkg::OP_JAL:
            begin
                pcSrc    = ctrlPkg::JUMP;
                regDst   = ctrlPkg::DST_LINK;
                regWrite = 1'b1;
            end

            isaPkg::OP_BEQ, isaPkg::OP_BNE, isaPkg::OP_BLEZ, isaPkg::OP_BGTZ:
            begin
                aluOp      = ctrlPkg::ALU_SUB; // Flags come from rs - rt
                pcSrc      = ctrlPkg::BRANCH;
                branchCond = opcode[1:0];
            end

            isaPkg::OP_ADDI, isaPkg::OP_ADDIU, isaPkg::OP_SLTI, isaPkg::OP_SLTIU,
            isaPkg::OP_ANDI, isaPkg::OP_ORI, isaPkg::OP_XORI, isaPkg::OP_LUI:
            begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                case (opcode)
                    isaPkg::OP_SLTI:  aluOp = ctrlPkg::ALU_SLT;
                    isaPkg::OP_SLTIU: aluOp = ctrlPkg::ALU_SLTU; // Still sign-extended
                    isaPkg::OP_ANDI:  aluOp = ctrlPkg::ALU_AND;
                    isaPkg::OP_ORI:   aluOp = ctrlPkg::ALU_OR;
                    isaPkg::OP_XORI:  aluOp = ctrlPkg::ALU_XOR;
                    isaPkg::OP_LUI:   aluOp = ctrlPkg::ALU_LUI;
                    default:          aluOp = ctrlPkg::ALU_ADD;
                endcase
                immZeroExt = (opcode == isaPkg::OP_ANDI) || (opcode == isaPkg::OP_ORI)
                          || (opcode == isaPkg::OP_XORI);
            end

            isaPkg::OP_LB, isaPkg::OP_LBU, isaPkg::OP_LW:
            begin
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
                regWrite  = 1'b1;
                if (opcode == isaPkg::OP_LB)
                    memSize = ctrlPkg::BYTE_S;
                else if (opcode == isaPkg::OP_LBU)
                    memSize = ctrlPkg::BYTE_U;
            end

            isaPkg::OP_SB, isaPkg::OP_SW:
            begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
                if (opcode == isaPkg::OP_SB)
                    memSize = ctrlPkg::BYTE_U;
            end

            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: design/fetchUnit.sv
////////////////////
// PC, next-PC choice and instruction memory.
// loadAddr is a word index; loads are taken only while rstN is low.
////////////////////
`default_nettype none

module fetchUnit #(
    parameter int imemWords = 256
) (
    input  wire logic                           clk,
    input  wire logic                           rstN,
    input  wire logic                           loadEn,
    input  wire logic [$clog2(imemWords)-1:0]   loadAddr,
    input  wire isaPkg::wordT                   loadData,
    input  wire ctrlPkg::pcSrcT                 pcSrc,
    input  wire logic [1:0]                     branchCond,
    input  wire logic                           zero,
    input  wire logic                           signBit,
    input  wire logic                           halt,
    input  wire isaPkg::wordT                   immOffset,
    input  wire logic [25:0]                    jumpTarget,
    input  wire isaPkg::wordT                   regTarget,
    output isaPkg::wordT                        instr,
    output isaPkg::wordT                        pc,
    output isaPkg::wordT                        pcPlus4,
    output logic                                halted
);

    localparam int imemAddrBits = $clog2(imemWords);

    isaPkg::wordT imem [imemWords];
    isaPkg::wordT nextPc;
    logic         taken;

    always_ff @(posedge clk)
    begin
        if (!rstN && loadEn)
            imem[loadAddr] <= loadData;
    end

    assign instr   = imem[pc[imemAddrBits+1:2]];
    assign pcPlus4 = pc + 32'd4;

    always_comb
    begin
        case (branchCond)
            2'(isaPkg::OP_BEQ):  taken = zero;
            2'(isaPkg::OP_BNE):  taken = !zero;
            2'(isaPkg::OP_BLEZ): taken = zero || signBit;
            default:             taken = !zero && !signBit; // BGTZ
        endcase

        case (pcSrc)
            ctrlPkg::BRANCH: nextPc = taken ? pcPlus4 + (immOffset << 2) : pcPlus4;
            ctrlPkg::JUMP:   nextPc = {pcPlus4[31:28], jumpTarget, 2'b00};
            ctrlPkg::JREG:   nextPc = regTarget;
            default:         nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            pc     <= '0;
            halted <= 1'b0;
        end
        else if (!halted)
        begin
            if (halt)
                halted <= 1'b1; // PC stays on the SYSCALL
            else
                pc <= nextPc;
        end
    end

    // Program loading belongs to reset only
    loadOnlyInReset: assert property (@(posedge clk) rstN |-> !loadEn);

endmodule

`default_nettype wire

// File: design/isaPkg.sv
////////////////////
// Encodings of the MIPS32 subset that the core executes.
// Values left out of the enums are not decoded and execute as no operation.
////////////////////
`default_nettype none

package isaPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    // Low bit of each instruction field
    localparam int opLsb    = 26;
    localparam int rsLsb    = 21;
    localparam int rtLsb    = 16;
    localparam int rdLsb    = 11;
    localparam int shamtLsb = 6;
    localparam int functLsb = 0;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04, // Low two bits select the branch test
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LB      = 6'h20,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_SB      = 6'h28,
        OP_SW      = 6'h2b
    } opcodeT;

    typedef enum logic [5:0] {
        FN_SLL     = 6'h00,
        FN_SRL     = 6'h02,
        FN_SRA     = 6'h03,
        FN_JR      = 6'h08,
        FN_SYSCALL = 6'h0c,
        FN_ADD     = 6'h20, // No overflow trap
        FN_ADDU    = 6'h21,
        FN_SUB     = 6'h22,
        FN_SUBU    = 6'h23,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_XOR     = 6'h26,
        FN_NOR     = 6'h27,
        FN_SLT     = 6'h2a,
        FN_SLTU    = 6'h2b
    } functT;

endpackage

`default_nettype wire

// File: design/regFile.sv
////////////////////
// Two read ports, one write port.
// Register 0 reads zero; no writes land during reset.
////////////////////
`default_nettype none

module regFile (
    input  wire logic            clk,
    input  wire logic            rstN,
    input  wire isaPkg::regAddrT readAddrA,
    input  wire isaPkg::regAddrT readAddrB,
    output isaPkg::wordT         readDataA,
    output isaPkg::wordT         readDataB,
    input  wire logic            writeEn,
    input  wire isaPkg::regAddrT writeAddr,
    input  wire isaPkg::wordT    writeData
);

    isaPkg::wordT regs [32];

    always_ff @(posedge clk)
    begin
        if (rstN && writeEn && writeAddr != 5'd0)
            regs[writeAddr] <= writeData;
    end

    // Combinational reads, old value during a same-cycle write
    assign readDataA = (readAddrA == 5'd0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == 5'd0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Compile and run the cpuCore testbench with Verilator, log in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f sim.f \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/VcpuTb > sim.log 2>&1 \
    ; cat sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "All tests passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// File: sim.f
design/isaPkg.sv
design/ctrlPkg.sv
design/decoder.sv
design/fetchUnit.sv
design/regFile.sv
design/alu.sv
design/dataMem.sv
design/cpuCore.sv
test/cpuChecker.sv
test/cpuTb.sv

// File: test/cpuCases.txt
# P <byte address hex> <instruction word hex>
# E <commit pc hex> <register decimal> <write value hex>, in commit order
P 00000000 20010005
P 00000004 2002fffd
P 00000008 00221820
P 0000000c 00222022
P 00000010 00222824
P 00000014 00223025
P 00000018 00223826
P 0000001c 00224027
P 00000020 0041482a
P 00000024 0041502b
P 00000028 00015900
P 0000002c 00026702
P 00000030 00026843
P 00000034 3c0e1234
P 00000038 35cf8001
P 0000003c 30508001
P 00000040 3831ffff
P 00000044 2852fffe
P 00000048 ac0f0008
P 0000004c 8c130008
P 00000050 a002000d
P 00000054 8014000d
P 00000058 9015000d
P 0000005c 10210001
P 00000060 20160001
P 00000064 14210001
P 00000068 20170007
P 0000006c 18400001
P 00000070 20180009
P 00000074 1c200001
P 00000078 2018000a
P 0000007c 1c400001
P 00000080 0c000024
P 00000084 20000005
P 00000088 20190011
P 0000008c 0000000c
P 00000090 201affff
P 00000094 03e00008
E 00000000 1 00000005
E 00000004 2 fffffffd
E 00000008 3 00000002
E 0000000c 4 00000008
E 00000010 5 00000005
E 00000014 6 fffffffd
E 00000018 7 fffffff8
E 0000001c 8 00000002
E 00000020 9 00000001
E 00000024 10 00000000
E 00000028 11 00000050
E 0000002c 12 0000000f
E 00000030 13 fffffffe
E 00000034 14 12340000
E 00000038 15 12348001
E 0000003c 16 00008001
E 00000040 17 0000fffa
E 00000044 18 00000001
E 0000004c 19 12348001
E 00000054 20 fffffffd
E 00000058 21 000000fd
E 00000068 23 00000007
E 00000080 31 00000084
E 00000090 26 ffffffff
E 00000088 25 00000011

// File: test/cpuChecker.sv
////////////////////
// Commit port checker for cpuCore.
// Expected writes are pushed in order while rstN is low.
// Each commit is compared by pc, register and data.
////////////////////
`default_nettype none

module cpuChecker (
    input  wire logic            clk,
    input  wire logic            rstN,
    input  wire logic            commitEn,
    input  wire isaPkg::regAddrT commitReg,
    input  wire isaPkg::wordT    commitData,
    input  wire isaPkg::wordT    commitPc,
    input  wire logic            halted,
    input  wire logic            expPush,
    input  wire isaPkg::wordT    expPc,
    input  wire isaPkg::regAddrT expReg,
    input  wire isaPkg::wordT    expData,
    output int                   mismatchCount,
    output int                   missingCount,
    output int                   extraCount
);

    timeunit 1ns;
    timeprecision 100ps;

    isaPkg::wordT    pcQ [$];
    isaPkg::regAddrT regQ [$];
    isaPkg::wordT    dataQ [$];
    logic            haltSeen;

    task automatic compareField(input string name, input isaPkg::wordT want,
                                input isaPkg::wordT got);
        if (got !== want)
        begin
            $display("FAIL %0t %s expected %0h actual %0h", $time, name, want, got);
            mismatchCount++;
        end
    endtask

    task automatic checkCommit;
        if (regQ.size() == 0)
        begin
            $display("%0t: commit to register %0d at pc %h came after the expected list ran out",
                     $time, commitReg, commitPc);
            extraCount++;
        end
        else
        begin
            compareField("commitPc", pcQ.pop_front(), commitPc);
            compareField("commitReg", {27'b0, regQ.pop_front()}, {27'b0, commitReg});
            compareField("commitData", dataQ.pop_front(), commitData);
        end
    endtask

    // Commit values are combinational, sampled before the edge takes effect
    always @(posedge clk)
    begin
        if (!rstN)
        begin
            mismatchCount = 0;
            missingCount  = 0;
            extraCount    = 0;
            haltSeen      = 1'b0;
            if (expPush)
            begin
                pcQ.push_back(expPc);
                regQ.push_back(expReg);
                dataQ.push_back(expData);
            end
        end
        else
        begin
            if (commitEn)
                checkCommit();
            if (halted && !haltSeen)
            begin
                haltSeen = 1'b1;
                if (regQ.size() != 0)
                begin
                    $display("%0t: core halted with %0d expected writes never committed, next at pc %h",
                             $time, regQ.size(), pcQ[0]);
                    missingCount = regQ.size();
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: test/cpuTb.sv
////////////////////
// Testbench for cpuCore. Loads test/cpuCases.txt while rstN is low,
// then runs until SYSCALL halts the core or the timeout hits.
// Run from the project root so the cases path resolves.
////////////////////
`default_nettype none

module cpuTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int imemWords   = 256;
    localparam int dmemWords   = 256;
    localparam int resetCycles = 10;

    logic                         clk;
    logic                         rstN;
    logic                         loadEn;
    logic [$clog2(imemWords)-1:0] loadAddr;
    isaPkg::wordT                 loadData;
    logic                         commitEn;
    isaPkg::regAddrT              commitReg;
    isaPkg::wordT                 commitData;
    isaPkg::wordT                 commitPc;
    logic                         halted;

    logic            expPush;
    isaPkg::wordT    expPc;
    isaPkg::regAddrT expReg;
    isaPkg::wordT    expData;
    int              mismatchCount;
    int              missingCount;
    int              extraCount;

    int           fd;
    string        line;
    isaPkg::wordT fieldA;
    isaPkg::wordT fieldB;
    int           regNum;
    int           progWords;
    int           timeoutCycles;
    int           cycles;
    logic         loadOk;
    logic         timedOut;

    cpuCore #(.imemWords(imemWords), .dmemWords(dmemWords)) cpuCore_inst (
        .clk(clk), .rstN(rstN), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .commitEn(commitEn), .commitReg(commitReg), .commitData(commitData),
        .commitPc(commitPc), .halted(halted)
    );

    cpuChecker checkerInst (
        .clk(clk), .rstN(rstN), .commitEn(commitEn), .commitReg(commitReg),
        .commitData(commitData), .commitPc(commitPc), .halted(halted),
        .expPush(expPush), .expPc(expPc), .expReg(expReg), .expData(expData),
        .mismatchCount(mismatchCount), .missingCount(missingCount), .extraCount(extraCount)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // One cases line per clock, comment lines take no cycle
    task automatic driveCases;
        while ($fgets(line, fd) != 0)
        begin
            loadEn  = 1'b0;
            expPush = 1'b0;
            if ($sscanf(line, "P %h %h", fieldA, fieldB) == 2)
            begin
                loadEn   = 1'b1;
                loadAddr = fieldA[$clog2(imemWords)+1:2]; // Byte address to word index
                loadData = fieldB;
                progWords++;
                @(posedge clk);
                #1;
            end
            else if ($sscanf(line, "E %h %d %h", fieldA, regNum, fieldB) == 3)
            begin
                expPush = 1'b1;
                expPc   = fieldA;
                expReg  = 5'(regNum);
                expData = fieldB;
                @(posedge clk);
                #1;
            end
        end
        loadEn  = 1'b0;
        expPush = 1'b0;
        $fclose(fd);
    endtask

    task automatic runUntilHalt;
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN   = 1'b1;
        cycles = 0;
        while (!halted && cycles < timeoutCycles)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    initial
    begin
        rstN          = 1'b0;
        loadEn        = 1'b0;
        loadAddr      = '0;
        loadData      = '0;
        expPush       = 1'b0;
        expPc         = '0;
        expReg        = '0;
        expData       = '0;
        progWords     = 0;
        timeoutCycles = 0;
        fd            = $fopen("test/cpuCases.txt", "r");
        loadOk        = (fd != 0);
        @(posedge clk);
        #1;
        if (loadOk)
        begin
            driveCases();
            timeoutCycles = progWords * 4 + 100;
            runUntilHalt();
        end
        else
            $display("Could not open test/cpuCases.txt for reading");
        timedOut = loadOk && !halted;
        if (timedOut)
            $display("Timeout: core did not halt within %0d cycles", timeoutCycles);
        repeat (2) @(posedge clk); // Let the checker see halted
        #1;
        $display("Errors: %0d mismatched fields, %0d missing writes, %0d extra commits",
                 mismatchCount, missingCount, extraCount);
        if (loadOk && !timedOut && mismatchCount + missingCount + extraCount == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire
